/* files.f */
+incdir+hdl
hdl/lpf_pkg.sv
hdl/dsp_slice.sv
hdl/dsp_arbiter.sv
hdl/taylor_eval.sv
hdl/lpf_coef_calc.sv
hdl/lpf_coef_top.sv
verif/lpf_coef_tb.sv

/* hdl/dsp_arbiter.sv */
`timescale 1ns/1ps
`include "lpf_cfg.svh"

module dsp_arbiter (
    input  logic              reset,
    input  logic              clk,
    input  logic              taylor_req_lvl,
    input  logic              coef_req_lvl,
    input  lpf_pkg::dsp_req_t taylor_req,
    input  lpf_pkg::dsp_req_t coef_req,
    output logic              taylor_gnt,
    output logic              coef_gnt,
    output lpf_pkg::dsp_req_t dsp_req
);

    // Slice owner
    localparam logic [1:0] OWN_NONE   = 2'd0;
    localparam logic [1:0] OWN_TAYLOR = 2'd1;
    localparam logic [1:0] OWN_COEF   = 2'd2;

    logic [1:0] owner;
    logic [1:0] owner_nxt;

    // ------------------------------------------------------------------
    // Grant
    // ------------------------------------------------------------------

    // Owner keeps the slice until its level drops
    always_comb begin
        owner_nxt = owner;
        case (owner)
            OWN_TAYLOR: begin
                if (!taylor_req_lvl) begin
                    owner_nxt = coef_req_lvl ? OWN_COEF : OWN_NONE;
                end
            end
            OWN_COEF: begin
                if (!coef_req_lvl) begin
                    owner_nxt = taylor_req_lvl ? OWN_TAYLOR : OWN_NONE;
                end
            end
            default: begin
                // Free slice, Taylor first
                if (taylor_req_lvl) begin
                    owner_nxt = OWN_TAYLOR;
                end else if (coef_req_lvl) begin
                    owner_nxt = OWN_COEF;
                end else begin
                    owner_nxt = OWN_NONE;
                end
            end
        endcase
    end

    always_ff @(posedge reset or posedge clk) begin
        if (clk) begin
            owner <= OWN_NONE;
        end else begin
            owner <= owner_nxt;
        end
    end

    assign taylor_gnt = (owner == OWN_TAYLOR);
    assign coef_gnt   = (owner == OWN_COEF);

    // ------------------------------------------------------------------
    // Request routing
    // ------------------------------------------------------------------

    // Idle request when nobody owns the slice
    always_comb begin
        case (owner)
            OWN_TAYLOR: dsp_req = taylor_req;
            OWN_COEF:   dsp_req = coef_req;
            default:    dsp_req = '0;
        endcase
    end

    // Single owner at a time
    assert property (@(posedge reset) disable iff (clk) !(taylor_gnt && coef_gnt));

    // Grant released one cycle after the level drops
    assert property (@(posedge reset) disable iff (clk) !taylor_req_lvl |=> !taylor_gnt);
    assert property (@(posedge reset) disable iff (clk) !coef_req_lvl |=> !coef_gnt);

endmodule

/* hdl/dsp_slice.sv */
`timescale 1ns/1ps
`include "lpf_cfg.svh"

module dsp_slice (
    input  logic              reset,
    input  logic              clk,
    input  lpf_pkg::dsp_req_t req,
    output lpf_pkg::dsp_rsp_t rsp
);

    // Stage 1 holds product and addend
    logic                      s1_valid;
    logic                      s1_sub;
    logic signed [`LPF_PW-1:0] s1_prod;
    logic signed [`LPF_PW-1:0] s1_c;

    // Stage 2 holds the sum
    logic                      s2_valid;
    logic signed [`LPF_PW-1:0] s2_p;

    // Valid pipe
    always_ff @(posedge reset or posedge clk) begin
        if (clk) begin
            s1_valid <= 1'b0;
            s2_valid <= 1'b0;
        end else begin
            s1_valid <= req.valid;
            s2_valid <= s1_valid;
        end
    end

    // Operand pipe
    always_ff @(posedge reset) begin
        // Full 36 bit signed product
        s1_prod <= req.a * req.b;
        s1_c    <= req.c;
        s1_sub  <= req.sub;
        // Post add or subtract
        s2_p    <= s1_sub ? (s1_c - s1_prod) : (s1_c + s1_prod);
    end

    assign rsp.valid = s2_valid;
    assign rsp.p     = s2_p;

endmodule

/* hdl/lpf_cfg.svh */
`ifndef LPF_CFG_SVH
`define LPF_CFG_SVH

// Data word width, Q2.16 signed
`define LPF_DW 18

// Fraction bits in a data word
`define LPF_FRAC 16

// Full product and addend width, Q4.32
`define LPF_PW 36

// Cycles from request valid to response valid
`define DSP_LAT 2

// Horner steps after the square
`define TAYLOR_TERMS 3

`endif

/* hdl/lpf_coef_calc.sv */
`timescale 1ns/1ps
`include "lpf_cfg.svh"

module lpf_coef_calc (
    input  logic                      reset,
    input  logic                      clk,
    input  logic signed [`LPF_DW-1:0] omega0,
    input  logic signed [`LPF_DW-1:0] inv_2q,
    input  logic                      do_calc,
    output lpf_pkg::coef_set_u        coefs,
    output logic                      calc_done,
    output logic                      taylor_start,
    output lpf_pkg::func_sel_e        taylor_func,
    output logic signed [`LPF_DW-1:0] taylor_x,
    input  logic                      taylor_done,
    input  logic signed [`LPF_DW-1:0] taylor_result,
    output logic                      dsp_req_lvl,
    input  logic                      dsp_gnt,
    output lpf_pkg::dsp_req_t         dsp_req,
    input  lpf_pkg::dsp_rsp_t         dsp_rsp
);

    localparam logic [3:0] ST_IDLE        = 4'd0;
    localparam logic [3:0] ST_SIN_START   = 4'd1;
    localparam logic [3:0] ST_SIN_WAIT    = 4'd2;
    localparam logic [3:0] ST_COS_START   = 4'd3;
    localparam logic [3:0] ST_COS_WAIT    = 4'd4;
    localparam logic [3:0] ST_ALPHA_REQ   = 4'd5;
    localparam logic [3:0] ST_ALPHA_ISSUE = 4'd6;
    localparam logic [3:0] ST_ALPHA_WAIT  = 4'd7;
    localparam logic [3:0] ST_FILL        = 4'd8;
    localparam logic [3:0] ST_DONE        = 4'd9;

    localparam logic signed [`LPF_DW-1:0] ONE_Q = `LPF_DW'(1) <<< `LPF_FRAC;

    logic [3:0]                state;
    logic signed [`LPF_DW-1:0] w0_r;
    logic signed [`LPF_DW-1:0] inv_2q_r;
    logic signed [`LPF_DW-1:0] sin_r;
    logic signed [`LPF_DW-1:0] cos_r;
    logic signed [`LPF_DW-1:0] alpha_r;
    logic signed [`LPF_DW-1:0] b1;
    logic signed [`LPF_DW-1:0] a1;
    logic signed [`LPF_DW-1:0] a2;

    // ------------------------------------------------------------------
    // Sequencer
    // ------------------------------------------------------------------
    always_ff @(posedge reset or posedge clk) begin
        if (clk) begin
            state <= ST_IDLE;
        end else begin
            case (state)
                // Restart requests outside idle are dropped
                ST_IDLE:        if (do_calc) state <= ST_SIN_START;
                ST_SIN_START:   state <= ST_SIN_WAIT;
                ST_SIN_WAIT:    if (taylor_done) state <= ST_COS_START;
                ST_COS_START:   state <= ST_COS_WAIT;
                ST_COS_WAIT:    if (taylor_done) state <= ST_ALPHA_REQ;
                ST_ALPHA_REQ:   if (dsp_gnt) state <= ST_ALPHA_ISSUE;
                ST_ALPHA_ISSUE: state <= ST_ALPHA_WAIT;
                ST_ALPHA_WAIT:  if (dsp_rsp.valid && dsp_gnt) state <= ST_FILL;
                ST_FILL:        state <= ST_DONE;
                default:        state <= ST_IDLE;
            endcase
        end
    end

    // Inputs frozen for the whole run
    always_ff @(posedge reset) begin
        if (state == ST_IDLE && do_calc) begin
            w0_r     <= omega0;
            inv_2q_r <= inv_2q;
        end
        if (state == ST_SIN_WAIT && taylor_done) begin
            sin_r <= taylor_result;
        end
        if (state == ST_COS_WAIT && taylor_done) begin
            cos_r <= taylor_result;
        end
        if (state == ST_ALPHA_WAIT && dsp_rsp.valid && dsp_gnt) begin
            alpha_r <= lpf_pkg::to_q(dsp_rsp.p);
        end
    end

    // Taylor control
    assign taylor_start = (state == ST_SIN_START) || (state == ST_COS_START);
    assign taylor_x     = w0_r;

    always_comb begin
        taylor_func = lpf_pkg::FUNC_SIN;
        if (state == ST_COS_START) begin
            taylor_func = lpf_pkg::FUNC_COS;
        end
    end

    // ------------------------------------------------------------------
    // Alpha multiply on the shared slice
    // ------------------------------------------------------------------
    assign dsp_req_lvl = (state == ST_ALPHA_REQ) || (state == ST_ALPHA_ISSUE) ||
                         (state == ST_ALPHA_WAIT);

    // sin times inv_2q with zero addend
    always_comb begin
        dsp_req       = '0;
        dsp_req.valid = (state == ST_ALPHA_ISSUE);
        dsp_req.a     = sin_r;
        dsp_req.b     = inv_2q_r;
    end

    // ------------------------------------------------------------------
    // Coefficient fill
    // ------------------------------------------------------------------
    assign b1 = ONE_Q - cos_r;
    // Wraps to the right code at cos of exactly 1.0
    assign a1 = -(cos_r <<< 1);
    assign a2 = ONE_Q - alpha_r;

    // Output word moves only with calc_done
    always_ff @(posedge reset or posedge clk) begin
        if (clk) begin
            coefs     <= '0;
            calc_done <= 1'b0;
        end else begin
            calc_done <= (state == ST_FILL);
            if (state == ST_FILL) begin
                coefs.w[lpf_pkg::COEF_B0] <= b1 >>> 1;
                coefs.w[lpf_pkg::COEF_B1] <= b1;
                coefs.w[lpf_pkg::COEF_B2] <= b1 >>> 1;
                coefs.w[lpf_pkg::COEF_A1] <= a1;
                coefs.w[lpf_pkg::COEF_A2] <= a2;
            end
        end
    end

    // One pulse per run
    assert property (@(posedge reset) disable iff (clk) calc_done |=> !calc_done);

endmodule

/* hdl/lpf_coef_top.sv */
`timescale 1ns/1ps
`include "lpf_cfg.svh"

module lpf_coef_top (
    input  logic                      reset,
    input  logic                      clk,
    input  logic signed [`LPF_DW-1:0] omega0,
    input  logic signed [`LPF_DW-1:0] inv_2q,
    input  logic                      do_calc,
    output lpf_pkg::coef_set_u        coefs,
    output logic                      calc_done
);

    // Sequencer to Taylor block
    logic                      taylor_start;
    lpf_pkg::func_sel_e        taylor_func;
    logic signed [`LPF_DW-1:0] taylor_x;
    logic                      taylor_done;
    logic signed [`LPF_DW-1:0] taylor_result;

    // Peers to arbiter
    logic              taylor_lvl;
    logic              coef_lvl;
    logic              taylor_gnt;
    logic              coef_gnt;
    lpf_pkg::dsp_req_t taylor_dsp_req;
    lpf_pkg::dsp_req_t coef_dsp_req;

    // Arbiter to slice, response fans out to both peers
    lpf_pkg::dsp_req_t dsp_req;
    lpf_pkg::dsp_rsp_t dsp_rsp;

    lpf_coef_calc lpf_coef_calc_inst (
        .reset         (reset),
        .clk           (clk),
        .omega0        (omega0),
        .inv_2q        (inv_2q),
        .do_calc       (do_calc),
        .coefs         (coefs),
        .calc_done     (calc_done),
        .taylor_start  (taylor_start),
        .taylor_func   (taylor_func),
        .taylor_x      (taylor_x),
        .taylor_done   (taylor_done),
        .taylor_result (taylor_result),
        .dsp_req_lvl   (coef_lvl),
        .dsp_gnt       (coef_gnt),
        .dsp_req       (coef_dsp_req),
        .dsp_rsp       (dsp_rsp)
    );

    taylor_eval taylor_eval_inst (
        .reset       (reset),
        .clk         (clk),
        .do_calc     (taylor_start),
        .func_sel    (taylor_func),
        .x_in        (taylor_x),
        .calc_done   (taylor_done),
        .result      (taylor_result),
        .dsp_req_lvl (taylor_lvl),
        .dsp_gnt     (taylor_gnt),
        .dsp_req     (taylor_dsp_req),
        .dsp_rsp     (dsp_rsp)
    );

    dsp_arbiter dsp_arbiter_inst (
        .reset          (reset),
        .clk            (clk),
        .taylor_req_lvl (taylor_lvl),
        .coef_req_lvl   (coef_lvl),
        .taylor_req     (taylor_dsp_req),
        .coef_req       (coef_dsp_req),
        .taylor_gnt     (taylor_gnt),
        .coef_gnt       (coef_gnt),
        .dsp_req        (dsp_req)
    );

    dsp_slice dsp_slice_inst (
        .reset (reset),
        .clk   (clk),
        .req   (dsp_req),
        .rsp   (dsp_rsp)
    );

endmodule

/* hdl/lpf_pkg.sv */
`include "lpf_cfg.svh"

package lpf_pkg;

    // ------------------------------------------------------------------
    // Shared multiply-add slice
    // ------------------------------------------------------------------

    // One operation for the slice
    typedef struct packed {
        logic                      valid;
        logic                      sub;   // Selects c minus a*b
        logic signed [`LPF_DW-1:0] a;
        logic signed [`LPF_DW-1:0] b;
        logic signed [`LPF_PW-1:0] c;     // Q4.32 addend
    } dsp_req_t;

    // Result, two cycles after the request
    typedef struct packed {
        logic                      valid;
        logic signed [`LPF_PW-1:0] p;
    } dsp_rsp_t;

    // Q4.32 result back to Q2.16 by truncation
    function automatic logic signed [`LPF_DW-1:0] to_q(input logic signed [`LPF_PW-1:0] p);
        return p[`LPF_FRAC+`LPF_DW-1:`LPF_FRAC];
    endfunction

    // Function picked for a Taylor run
    typedef enum logic {
        FUNC_SIN = 1'b0,
        FUNC_COS = 1'b1
    } func_sel_e;

    // ------------------------------------------------------------------
    // Coefficient set
    // ------------------------------------------------------------------

    // Named view, b0 in the top bits
    typedef struct packed {
        logic signed [`LPF_DW-1:0] b0;
        logic signed [`LPF_DW-1:0] b1;
        logic signed [`LPF_DW-1:0] b2;
        logic signed [`LPF_DW-1:0] a1;
        logic signed [`LPF_DW-1:0] a2;
    } coef_fields_t;

    // Word index of each named field
    localparam int COEF_B0 = 4;
    localparam int COEF_B1 = 3;
    localparam int COEF_B2 = 2;
    localparam int COEF_A1 = 1;
    localparam int COEF_A2 = 0;

    // Same 90 bits seen by name or by index
    typedef union packed {
        coef_fields_t              f;
        logic [4:0][`LPF_DW-1:0]   w;
    } coef_set_u;

endpackage

/* hdl/taylor_eval.sv */
`timescale 1ns/1ps
`include "lpf_cfg.svh"

module taylor_eval (
    input  logic                      reset,
    input  logic                      clk,
    input  logic                      do_calc,
    input  lpf_pkg::func_sel_e        func_sel,
    input  logic signed [`LPF_DW-1:0] x_in,
    output logic                      calc_done,
    output logic signed [`LPF_DW-1:0] result,
    output logic                      dsp_req_lvl,
    input  logic                      dsp_gnt,
    output lpf_pkg::dsp_req_t         dsp_req,
    input  lpf_pkg::dsp_rsp_t         dsp_rsp
);

    localparam logic [1:0] ST_IDLE  = 2'd0;
    localparam logic [1:0] ST_REQ   = 2'd1;
    localparam logic [1:0] ST_ISSUE = 2'd2;
    localparam logic [1:0] ST_WAIT  = 2'd3;

    // Step 0 is the square, then the Horner steps
    localparam int SW = $clog2(`TAYLOR_TERMS + 1);
    localparam int CW = $clog2(`DSP_LAT + 1);

    // 1.0 as a data word and as an addend
    localparam logic signed [`LPF_DW-1:0] ONE_Q = `LPF_DW'(1) <<< `LPF_FRAC;
    localparam logic signed [`LPF_PW-1:0] ONE_C = `LPF_PW'(1) <<< (2 * `LPF_FRAC);

    logic [1:0]                state;
    logic [SW-1:0]             step;
    logic [CW-1:0]             cnt;
    logic                      rsp_here;
    logic signed [`LPF_DW-1:0] x_r;
    logic signed [`LPF_DW-1:0] y_r;    // Half of x squared
    logic signed [`LPF_DW-1:0] acc_r;
    lpf_pkg::func_sel_e        func_r;

    // Series on y = x*x/2
    //   sin = x * (1 - y * (1/3 - y/30))
    //   cos = 1 * (1 - y * (1 - y/6))
    // Truncated Q2.16 reciprocals
    function automatic logic signed [`LPF_DW-1:0] rcp(input lpf_pkg::func_sel_e f,
                                                     input logic idx);
        logic signed [`LPF_DW-1:0] k;
        case ({f, idx})
            {lpf_pkg::FUNC_SIN, 1'b0}: k = 18'sd21845;  // 1/3
            {lpf_pkg::FUNC_SIN, 1'b1}: k = 18'sd2184;   // 1/30
            {lpf_pkg::FUNC_COS, 1'b0}: k = 18'sd65536;  // 1
            default:                   k = 18'sd10922;  // 1/6
        endcase
        return k;
    endfunction

    // ------------------------------------------------------------------
    // Operand select per step
    // ------------------------------------------------------------------
    always_comb begin
        dsp_req       = '0;
        dsp_req.valid = (state == ST_ISSUE);
        case (step)
            SW'(0): begin
                // x times x/2
                dsp_req.a = x_r;
                dsp_req.b = x_r >>> 1;
            end
            SW'(1): begin
                dsp_req.sub = 1'b1;
                dsp_req.a   = y_r;
                dsp_req.b   = rcp(func_r, 1'b1);
                dsp_req.c   = `LPF_PW'(rcp(func_r, 1'b0)) <<< `LPF_FRAC;
            end
            SW'(2): begin
                dsp_req.sub = 1'b1;
                dsp_req.a   = y_r;
                dsp_req.b   = acc_r;
                dsp_req.c   = ONE_C;
            end
            default: begin
                // Outer factor, x for sin and 1 for cos
                dsp_req.a = acc_r;
                dsp_req.b = (func_r == lpf_pkg::FUNC_SIN) ? x_r : ONE_Q;
            end
        endcase
    end

    // Slice result due this cycle
    assign rsp_here = (state == ST_WAIT) && (cnt == CW'(`DSP_LAT));

    // ------------------------------------------------------------------
    // FSM
    // ------------------------------------------------------------------
    always_ff @(posedge reset or posedge clk) begin
        if (clk) begin
            state     <= ST_IDLE;
            step      <= '0;
            cnt       <= '0;
            calc_done <= 1'b0;
        end else begin
            calc_done <= 1'b0;
            case (state)
                ST_IDLE: begin
                    if (do_calc) begin
                        state <= ST_REQ;
                        step  <= '0;
                    end
                end
                ST_REQ: begin
                    if (dsp_gnt) begin
                        state <= ST_ISSUE;
                    end
                end
                ST_ISSUE: begin
                    state <= ST_WAIT;
                    cnt   <= CW'(1);
                end
                default: begin
                    cnt <= cnt + 1'b1;
                    if (rsp_here) begin
                        if (step == SW'(`TAYLOR_TERMS)) begin
                            calc_done <= 1'b1;
                            state     <= ST_IDLE;
                        end else begin
                            step  <= step + 1'b1;
                            state <= ST_ISSUE;
                        end
                    end
                end
            endcase
        end
    end

    // Operands and partial results
    always_ff @(posedge reset) begin
        if (state == ST_IDLE && do_calc) begin
            x_r    <= x_in;
            func_r <= func_sel;
        end
        if (rsp_here) begin
            if (step == SW'(0)) begin
                y_r <= lpf_pkg::to_q(dsp_rsp.p);
            end else if (step == SW'(`TAYLOR_TERMS)) begin
                result <= lpf_pkg::to_q(dsp_rsp.p);
            end else begin
                acc_r <= lpf_pkg::to_q(dsp_rsp.p);
            end
        end
    end

    // Level held from start through the last response
    assign dsp_req_lvl = (state != ST_IDLE);

    // Issue only under a grant from the arbiter
    assert property (@(posedge reset) disable iff (clk) dsp_req.valid |-> dsp_gnt);

endmodule

/* verif/coef_input.txt */
// Columns: omega0 inv_2q b0 b1 b2 a1 a2, each an 18 bit Q2.16 word in hex
// Expected words follow truncating Q2.16 arithmetic on the Taylor series
00000 0B505 00000 00000 00000 20000 10000
08000 08000 00FAB 01F56 00FAB 23EAC 0C2A3
10000 0B505 03AAB 07556 03AAB 2EAAC 067A5
04000 10000 003FB 007F6 003FB 20FEC 0C0AB
18000 04000 07500 0EA00 07500 3D400 0BFF4
0C000 02000 02250 044A0 02250 28940 0EA30
02000 0B505 00100 00200 00100 20400 0E96F
14000 08000 056FB 0ADF6 056FB 35BEC 0866A

/* verif/lpf_coef_tb.sv */
`timescale 1ns/1ps
`include "lpf_cfg.svh"

module lpf_coef_tb;

    localparam int TIMEOUT_CYCLES = 500;

    // Longer than one whole run of the DUT
    localparam int RESTART_WINDOW = 50;

    // One line of the vector file
    typedef struct packed {
        logic [`LPF_DW-1:0]    w0;
        logic [`LPF_DW-1:0]    iq;
        lpf_pkg::coef_fields_t exp;
    } vec_t;

    // DUT ports, clock on reset and async reset on clk
    logic                      reset;
    logic                      clk;
    logic signed [`LPF_DW-1:0] omega0;
    logic signed [`LPF_DW-1:0] inv_2q;
    logic                      do_calc;
    lpf_pkg::coef_set_u        coefs;
    logic                      calc_done;

    vec_t        vecs[$];
    logic [31:0] lfsr;
    int          done_count;
    int          pass_count;
    int          fail_count;
    bit          timed_out;

    lpf_coef_top lpf_coef_top_inst (
        .reset     (reset),
        .clk       (clk),
        .omega0    (omega0),
        .inv_2q    (inv_2q),
        .do_calc   (do_calc),
        .coefs     (coefs),
        .calc_done (calc_done)
    );

    // 4 ns period
    always #2 reset = ~reset;

    // Done pulses counted on the falling edge, away from updates
    always @(negedge reset) begin
        if (!clk && calc_done === 1'b1) begin
            done_count = done_count + 1;
        end
    end

    // ------------------------------------------------------------------
    // Helpers
    // ------------------------------------------------------------------

    // Galois LFSR, taps for x^32+x^22+x^2+x+1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        logic [31:0] n;
        if (s[0]) begin
            n = (s >> 1) ^ 32'h8020_0003;
        end else begin
            n = s >> 1;
        end
        return n;
    endfunction

    // Shift out n bits, one LFSR step each
    task automatic rand_bits(input int n, output int val);
        int k;
        val = 0;
        for (k = 0; k < n; k++) begin
            val = (val << 1) | int'(lfsr[0]);
            lfsr = lfsr_next(lfsr);
        end
    endtask

    // Next rising edge plus drive delay
    task automatic step_cycle();
        @(posedge reset);
        #0.5;
    endtask

    task automatic load_vectors();
        int          fd;
        int          code;
        string       line;
        logic [17:0] v[7];
        vec_t        vec;
        fd = $fopen("verif/coef_input.txt", "r");
        if (fd == 0) begin
            $display("Could not open the vector file verif/coef_input.txt");
            fail_count++;
        end else begin
            while (!$feof(fd)) begin
                code = $fgets(line, fd);
                // Comment and blank lines give fewer than seven fields
                if (code != 0 && $sscanf(line, "%h %h %h %h %h %h %h",
                        v[0], v[1], v[2], v[3], v[4], v[5], v[6]) == 7) begin
                    vec.w0     = v[0];
                    vec.iq     = v[1];
                    vec.exp.b0 = v[2];
                    vec.exp.b1 = v[3];
                    vec.exp.b2 = v[4];
                    vec.exp.a1 = v[5];
                    vec.exp.a2 = v[6];
                    vecs.push_back(vec);
                end
            end
            $fclose(fd);
        end
    endtask

    task automatic check_word(input string name, input string field,
                              input logic [17:0] exp, input logic [17:0] act,
                              inout int errs);
        if (act !== exp) begin
            $display("ERROR %s: %s expected %05h actual %05h", name, field, exp, act);
            errs++;
        end
    endtask

    task automatic finish_test(input string name, input int errs);
        if (errs == 0) begin
            pass_count++;
            $display("%s: ok", name);
        end else begin
            fail_count++;
            $display("%s: failed with %0d errors", name, errs);
        end
    endtask

    // Idle cycles, output word must hold
    task automatic idle_hold(input int cycles, input string name, inout int errs);
        lpf_pkg::coef_set_u held;
        int                 k;
        held = coefs;
        for (k = 0; k < cycles; k++) begin
            step_cycle();
            if (coefs !== held) begin
                $display("ERROR %s: coefs expected %h actual %h", name, held, coefs);
                errs++;
            end
            if (calc_done !== 1'b0) begin
                $display("%s: calc_done pulsed while no run was active", name);
                errs++;
            end
        end
    endtask

    // ------------------------------------------------------------------
    // One run, with an optional second do_calc three cycles in
    // ------------------------------------------------------------------
    task automatic run_calc(input vec_t v, input bit restart, input vec_t alt,
                            input string name, output int errs);
        lpf_pkg::coef_set_u held;
        int                 start_count;
        int                 waited;
        int                 diff;
        bit                 seen;
        errs        = 0;
        held        = coefs;
        start_count = done_count;
        omega0      = v.w0;
        inv_2q      = v.iq;
        do_calc     = 1'b1;
        step_cycle();
        waited = 0;
        seen   = 1'b0;
        while (!seen && waited < TIMEOUT_CYCLES) begin
            if (restart && waited == 3) begin
                // Different inputs mid run
                omega0  = alt.w0;
                inv_2q  = alt.iq;
                do_calc = 1'b1;
            end else begin
                do_calc = 1'b0;
            end
            step_cycle();
            waited++;
            if (calc_done === 1'b1) begin
                seen = 1'b1;
            end else if (coefs !== held) begin
                $display("ERROR %s: coefs expected %h actual %h", name, held, coefs);
                errs++;
            end
        end
        do_calc = 1'b0;
        if (!seen) begin
            $display("%s: calc_done did not arrive within %0d cycles", name, TIMEOUT_CYCLES);
            errs++;
            timed_out = 1'b1;
        end else begin
            // Against the file, by name
            check_word(name, "b0", v.exp.b0, coefs.f.b0, errs);
            check_word(name, "b1", v.exp.b1, coefs.f.b1, errs);
            check_word(name, "b2", v.exp.b2, coefs.f.b2, errs);
            check_word(name, "a1", v.exp.a1, coefs.f.a1, errs);
            check_word(name, "a2", v.exp.a2, coefs.f.a2, errs);
            // Structure of the result alone
            check_word(name, "b2 vs b0", coefs.f.b0, coefs.f.b2, errs);
            diff = int'(coefs.f.b1) - 2 * int'(coefs.f.b0);
            if (diff < -1 || diff > 1) begin
                $display("ERROR %s: b1 expected %05h actual %05h",
                         name, 18'(2 * int'(coefs.f.b0)), coefs.f.b1);
                errs++;
            end
            // Counter catches a second pulse
            idle_hold(2, name, errs);
            if (done_count - start_count != 1) begin
                $display("%s: expected one calc_done pulse but saw %0d",
                         name, done_count - start_count);
                errs++;
            end
        end
    endtask

    // ------------------------------------------------------------------
    // Main sequence
    // ------------------------------------------------------------------
    initial begin
        int    errs;
        int    gap;
        int    i;
        string name;
        reset      = 1'b0;
        clk        = 1'b1;
        omega0     = '0;
        inv_2q     = '0;
        do_calc    = 1'b0;
        lfsr       = 32'hbc9e;
        done_count = 0;
        pass_count = 0;
        fail_count = 0;
        timed_out  = 1'b0;
        load_vectors();

        // Reset for 10 cycles
        repeat (10) step_cycle();
        clk = 1'b0;

        // Quiet outputs before any do_calc
        errs = 0;
        repeat (3) step_cycle();
        if (calc_done !== 1'b0) begin
            $display("reset_state: calc_done high before any run");
            errs++;
        end
        if (coefs !== '0) begin
            $display("ERROR reset_state: coefs expected %h actual %h", 90'h0, coefs);
            errs++;
        end
        finish_test("reset_state", errs);

        // File vectors with random idle gaps
        for (i = 0; i < vecs.size() && !timed_out; i++) begin
            name = $sformatf("vector_%0d", i);
            run_calc(vecs[i], 1'b0, vecs[i], name, errs);
            if (!timed_out) begin
                rand_bits(4, gap);
                idle_hold(gap, name, errs);
            end
            finish_test(name, errs);
        end

        if (!timed_out && vecs.size() >= 4) begin
            // Second do_calc with other inputs is dropped
            run_calc(vecs[1], 1'b1, vecs[2], "restart_ignored", errs);
            // A queued second run would pulse about one run later
            if (!timed_out) begin
                idle_hold(RESTART_WINDOW, "restart_ignored", errs);
            end
            finish_test("restart_ignored", errs);
        end

        if (!timed_out && vecs.size() >= 4) begin
            errs = 0;
            idle_hold(20, "hold_idle", errs);
            finish_test("hold_idle", errs);
            // Hold until the next calc_done is checked inside the run
            run_calc(vecs[3], 1'b0, vecs[3], "hold_next_run", errs);
            finish_test("hold_next_run", errs);
        end

        $display("Summary: %0d passed, %0d failed", pass_count, fail_count);
        if (fail_count == 0 && vecs.size() > 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule
